/* logic/control_pkg.sv */
`default_nettype none

package control_pkg;

    // listener controls, sampled on every clock.
    typedef struct packed {
        logic [2:0] speed_code;
        logic [2:0] pitch_code;
        logic [1:0] skip_code;
    } player_ctrl_t;

    typedef logic [3:0]        quarters_t;   // speed in quarters of normal.
    typedef logic signed [3:0] offset_t;     // signed step for pitch or index.

    // 0.25x up to 3x, code 4 and code 0 are normal speed.
    function automatic quarters_t speed_quarters(input logic [2:0] speed_code);
        case (speed_code)
            3'd1:    return 4'd1;
            3'd2:    return 4'd2;
            3'd3:    return 4'd3;
            3'd5:    return 4'd6;
            3'd6:    return 4'd8;
            3'd7:    return 4'd12;
            default: return 4'd4;
        endcase
    endfunction

    // codes 1 to 7 give -3 to +3.
    function automatic offset_t pitch_shift(input logic [2:0] pitch_code);
        if (pitch_code == 3'd0) begin
            return 4'sd0;
        end
        return offset_t'(signed'({1'b0, pitch_code})) - 4'sd4;
    endfunction

    // index step per beat, including the normal step of one.
    function automatic offset_t skip_step(input logic [1:0] skip_code);
        case (skip_code)
            2'd1:    return 4'sd6;    // forward five notes.
            2'd2:    return -4'sd4;   // back five notes.
            default: return 4'sd1;
        endcase
    endfunction

endpackage

`default_nettype wire

/* logic/note_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module note_sequencer (
    input  wire logic          iClk,
    input  wire logic          iReset_n,
    input  wire logic          enable,
    input  wire logic          beat,
    input  wire logic [1:0]    skip_code,
    output logic               playing,
    output tune_pkg::note_index_t note_index,
    output tune_pkg::percent_t    progress
);
    import tune_pkg::*;
    import control_pkg::*;

    typedef enum logic {
        IDLE,
        PLAY
    } state_t;

    state_t            state;
    logic signed [8:0] idx_sum;      // wide enough to see a step below zero.
    note_index_t       next_index;
    int unsigned       scaled;

    // the player simply follows the enable level.
    always_ff @(posedge iClk or negedge iReset_n) begin
        if (!iReset_n) begin
            state <= IDLE;
        end
        else begin
            state <= enable ? PLAY : IDLE;
        end
    end

    assign playing = (state == PLAY);

    assign idx_sum = $signed({2'b00, note_index}) + skip_step(skip_code);

    always_comb begin
        if (idx_sum < 0 || idx_sum >= $signed(9'(SONG_LENGTH))) begin
            next_index = '0;   // off either end, start over.
        end
        else begin
            next_index = note_index_t'(idx_sum);
        end
    end

    assign scaled = (int'(note_index) * 100) / SONG_LENGTH;

    always_ff @(posedge iClk or negedge iReset_n) begin
        if (!iReset_n) begin
            note_index <= '0;
            progress   <= '0;
        end
        else if (!enable) begin
            note_index <= '0;
            progress   <= '0;
        end
        else begin
            case (state)
                PLAY: begin
                    if (beat) begin
                        note_index <= next_index;
                    end
                end
                default: note_index <= '0;
            endcase
            progress <= percent_t'(scaled);   // lags the index by one cycle.
        end
    end

endmodule

`default_nettype wire

/* logic/note_voice.sv */
`timescale 1ns/1ps
`default_nettype none

module note_voice (
    input  wire logic             iClk,
    input  wire logic             iReset_n,
    input  wire logic             playing,
    input  wire tune_pkg::note_index_t note_index,
    input  wire logic [2:0]       pitch_code,
    output tune_pkg::note_code_t  freq
);
    import tune_pkg::*;
    import control_pkg::*;

    localparam int unsigned ADDR_W = $clog2(SONG_LENGTH);

    note_code_t song_rom [SONG_LENGTH];
    note_code_t table_q;
    note_code_t shift_ext;

    initial begin
        $readmemh(SONG_FILE, song_rom);
    end

    // stage one, synchronous table read.
    always_ff @(posedge iClk) begin
        table_q <= song_rom[note_index[ADDR_W-1:0]];
    end

    // sign extend so a downward shift wraps within 8 bits.
    assign shift_ext = note_code_t'(pitch_shift(pitch_code));

    // stage two.
    always_ff @(posedge iClk or negedge iReset_n) begin
        if (!iReset_n) begin
            freq <= '0;
        end
        else if (!playing) begin
            freq <= '0;   // silent while idle.
        end
        else begin
            freq <= table_q + shift_ext;
        end
    end

endmodule

`default_nettype wire

/* logic/song.hex */
// one note code per line in hex, table index 0 first; 64 marks a rest.
02
30
34
37
3C
37
34
30
64
30
32
34
35
37
39
3B
3C
64
3C
3B
39
37
35
34
32
30
2F
30
64
64
FE
30
28
2B
2F
30
32
34
35
37
64
37
35
34
32
30
2F
2D
2B
28
64
28
2B
2D
2F
30
32
34
64
30
2F
2D
2B
28

/* logic/tempo_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module tempo_timer #(
    parameter int unsigned BASE_PERIOD = 99219
) (
    input  wire logic       iClk,
    input  wire logic       iReset_n,
    input  wire logic       playing,
    input  wire logic [2:0] speed_code,
    output logic            beat
);
    import control_pkg::*;

    localparam int unsigned CNT_W = $clog2(BASE_PERIOD * 4 + 1);

    logic [CNT_W-1:0] period_lut [8];
    logic [CNT_W-1:0] period;
    logic [CNT_W-1:0] count;

    // one constant period per speed code.
    for (genvar s = 0; s < 8; s++) begin : g_period
        localparam int unsigned PERIOD = (BASE_PERIOD * 4) / speed_quarters(3'(s));
        assign period_lut[s] = CNT_W'(PERIOD);
    end

    assign period = period_lut[speed_code];

    // >= so a switch to a shorter period beats at once.
    assign beat = playing && (count >= period - CNT_W'(1));

    always_ff @(posedge iClk or negedge iReset_n) begin
        if (!iReset_n) begin
            count <= '0;
        end
        else if (!playing || beat) begin
            count <= '0;
        end
        else begin
            count <= count + CNT_W'(1);
        end
    end

endmodule

`default_nettype wire

/* logic/tune_pkg.sv */
`default_nettype none

package tune_pkg;

    // pitch code as stored in the melody table.
    typedef logic [7:0] note_code_t;

    // position in the song, one bit wider than the table needs.
    typedef logic [6:0] note_index_t;

    // progress through the song in percent, 0 to 98.
    typedef logic [7:0] percent_t;

    localparam note_code_t REST_CODE = 8'd100;   // silence marker inside the table.

    // first two phrases only, so the song ends where the table ends.
    localparam int unsigned SONG_LENGTH = 64;

    localparam string SONG_FILE = "logic/song.hex";

endpackage

`default_nettype wire

/* logic/tune_player.sv */
`timescale 1ns/1ps
`default_nettype none

module tune_player #(
    parameter int unsigned BASE_PERIOD = 99219   // cycles per note at normal speed.
) (
    input  wire logic                      iClk,
    input  wire logic                      iReset_n,
    input  wire logic                      enable,
    input  wire control_pkg::player_ctrl_t ctrl,
    output tune_pkg::note_code_t           freq,
    output tune_pkg::percent_t             progress
);
    import tune_pkg::*;

    logic        playing;
    logic        beat;
    note_index_t note_index;

    tempo_timer #(
        .BASE_PERIOD (BASE_PERIOD)
    ) timer0 (
        .iClk       (iClk),
        .iReset_n   (iReset_n),
        .playing    (playing),
        .speed_code (ctrl.speed_code),
        .beat       (beat)
    );

    note_sequencer seq0 (
        .iClk       (iClk),
        .iReset_n   (iReset_n),
        .enable     (enable),
        .beat       (beat),
        .skip_code  (ctrl.skip_code),
        .playing    (playing),
        .note_index (note_index),
        .progress   (progress)
    );

    note_voice voice0 (
        .iClk       (iClk),
        .iReset_n   (iReset_n),
        .playing    (playing),
        .note_index (note_index),
        .pitch_code (ctrl.pitch_code),
        .freq       (freq)
    );

endmodule

`default_nettype wire

/* project.f */
logic/tune_pkg.sv
logic/control_pkg.sv
logic/tempo_timer.sv
logic/note_sequencer.sv
logic/note_voice.sv
logic/tune_player.sv
testbench/tb_tune_player.sv

/* run.sh */
#!/bin/sh
# compile and run the tune player testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_tune_player -f project.f

out=$(./obj_dir/Vtb_tune_player 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

/* testbench/tb_tune_player.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tune_player;
    import tune_pkg::*;
    import control_pkg::*;

    localparam int unsigned BASE_PERIOD  = 24;
    localparam int unsigned RAND_SEED    = 67319;
    localparam int unsigned RESET_CYCLES = 2;
    localparam int unsigned IDLE_CYCLES  = 10;
    localparam int unsigned WALK_CYCLES  = 66 * BASE_PERIOD;   // past the wrap from 63.
    localparam int unsigned SPEED_SEG    = 200;
    localparam int unsigned PITCH_SEG    = 60;
    localparam int unsigned SKIP_RUN     = 20 * 8;             // twenty beats at speed 7.
    localparam int unsigned RANDOM_SEGS  = 30;
    localparam int unsigned RANDOM_SEG   = 40;
    localparam int unsigned STIM_CYCLES  = RESET_CYCLES + 2 * IDLE_CYCLES + WALK_CYCLES + 5
                                         + 8 * SPEED_SEG + 3 * 2 + 90 + 20 + 142
                                         + 8 * PITCH_SEG + 2 * SKIP_RUN
                                         + RANDOM_SEGS * RANDOM_SEG;

    logic         iClk;
    logic         iReset_n;
    logic         enable;
    player_ctrl_t ctrl;
    note_code_t   freq;
    percent_t     progress;

    logic [7:0]   song_ref [SONG_LENGTH];
    logic         m_playing;
    int           m_count;
    int           m_index;
    logic [7:0]   m_table_q;
    logic [7:0]   m_freq;
    logic [7:0]   m_progress;

    tune_player #(
        .BASE_PERIOD (BASE_PERIOD)
    ) dut0 (
        .iClk     (iClk),
        .iReset_n (iReset_n),
        .enable   (enable),
        .ctrl     (ctrl),
        .freq     (freq),
        .progress (progress)
    );

    initial begin
        iClk = 1'b0;
        forever #20 iClk = ~iClk;
    end

    // beat period in cycles for each speed code.
    function automatic int expected_period(input logic [2:0] code);
        int q;
        case (code)
            3'd1:    q = 1;
            3'd2:    q = 2;
            3'd3:    q = 3;
            3'd5:    q = 6;
            3'd6:    q = 8;
            3'd7:    q = 12;
            default: q = 4;
        endcase
        return int'(BASE_PERIOD) * 4 / q;
    endfunction

    function automatic int pitch_offset(input logic [2:0] code);
        return (code == 3'd0) ? 0 : int'(code) - 4;
    endfunction

    function automatic int index_step(input logic [1:0] code);
        case (code)
            2'd1:    return 6;
            2'd2:    return -4;
            default: return 1;
        endcase
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input int expected, input int actual);
        stop_with_failure($sformatf("Mismatch at %0t: %s expected %0d, got %0d",
                                    $time, what, expected, actual));
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(negedge iClk);
    endtask

    task automatic set_ctrl(input int speed, input int pitch, input int skip);
        ctrl.speed_code = 3'(speed);
        ctrl.pitch_code = 3'(pitch);
        ctrl.skip_code  = 2'(skip);
    endtask

    // drop enable long enough for the player to go idle.
    task automatic restart_play();
        enable = 1'b0;
        run_cycles(2);
        enable = 1'b1;
    endtask

    // cycle-accurate reference model of the player.
    always @(posedge iClk or negedge iReset_n) begin
        int   sum;
        logic beat_now;
        if (!iReset_n) begin
            m_playing  = 1'b0;
            m_count    = 0;
            m_index    = 0;
            m_table_q  = song_ref[0];
            m_freq     = 8'd0;
            m_progress = 8'd0;
        end
        else begin
            beat_now = m_playing && (m_count >= expected_period(ctrl.speed_code) - 1);
            sum = m_index + index_step(ctrl.skip_code);
            if (sum < 0 || sum >= int'(SONG_LENGTH)) begin
                sum = 0;   // off either end.
            end
            m_freq     = m_playing ? 8'(int'(m_table_q) + pitch_offset(ctrl.pitch_code)) : 8'd0;
            m_table_q  = song_ref[m_index];
            m_progress = enable ? 8'(m_index * 100 / int'(SONG_LENGTH)) : 8'd0;
            m_count    = (!m_playing || beat_now) ? 0 : m_count + 1;
            if (!enable || !m_playing) begin
                m_index = 0;
            end
            else if (beat_now) begin
                m_index = sum;
            end
            m_playing = enable;
        end
    end

    // registered outputs are settled by the falling edge.
    always @(negedge iClk) begin
        if (iReset_n) begin
            assert (freq == m_freq)
                else report_mismatch("freq", m_freq, freq);
            assert (progress == m_progress)
                else report_mismatch("progress", m_progress, progress);
        end
    end

    initial begin
        repeat (STIM_CYCLES + 200) @(posedge iClk);
        stop_with_failure("Watchdog timeout: the stimulus did not finish in time");
    end

    initial begin
        iReset_n = 1'b0;
        enable   = 1'b0;
        ctrl     = '0;
        void'($urandom(RAND_SEED));
        $readmemh(SONG_FILE, song_ref);
        if ($isunknown(song_ref[0]) || $isunknown(song_ref[SONG_LENGTH-1])) begin
            stop_with_failure("Could not read the song table file");
        end
        repeat (RESET_CYCLES) @(posedge iClk);
        @(negedge iClk);
        iReset_n = 1'b1;
        run_cycles(IDLE_CYCLES);

        // whole song in order at normal speed.
        set_ctrl(4, 4, 0);
        enable = 1'b1;
        run_cycles(WALK_CYCLES);
        enable = 1'b0;   // stop in mid-song.
        run_cycles(5);

        enable = 1'b1;
        for (int code = 0; code < 8; code++) begin
            set_ctrl(code, 4, 0);
            run_cycles($urandom_range(SPEED_SEG, BASE_PERIOD));
        end
        restart_play();
        set_ctrl(1, 4, 0);
        run_cycles(50);
        set_ctrl(7, 4, 0);   // count already past the short period.
        run_cycles(40);

        restart_play();
        set_ctrl(4, 1, 0);   // first entry shifted below zero.
        run_cycles(20);
        restart_play();
        set_ctrl(4, 7, 1);
        run_cycles(122);     // five skips land on entry 30.
        set_ctrl(4, 7, 0);
        run_cycles(20);
        for (int code = 0; code < 8; code++) begin
            set_ctrl(4, code, 0);
            run_cycles($urandom_range(PITCH_SEG, 10));
        end

        set_ctrl(7, 4, 1);
        run_cycles(SKIP_RUN);
        set_ctrl(7, 4, 2);
        run_cycles(SKIP_RUN);
        for (int i = 0; i < RANDOM_SEGS; i++) begin
            set_ctrl($urandom_range(7, 0), $urandom_range(7, 0), $urandom_range(3, 0));
            run_cycles($urandom_range(RANDOM_SEG, 8));
        end

        enable = 1'b0;
        run_cycles(IDLE_CYCLES);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
